/* verif/spikeCases.txt */
# id wait drawX drawY kidX kidY isSpike spikeAddr(hex) hitSpike, decimal unless noted
# wait counts clock edges with these inputs before the outputs are checked
1 1 111 108 0 0 1 384F 0
1 1 111 107 0 0 0 0 0
1 1 97 137 0 0 1 3BE1 0
1 1 96 137 0 0 0 0 0
1 1 126 137 0 0 1 3BFE 0
1 1 104 122 0 0 1 3A08 0
1 3 0 0 0 0 0 0 0
2 1 0 0 160 75 0 0 1
2 1 0 0 160 74 0 0 0
2 1 0 0 153 75 0 0 1
2 1 0 0 152 75 0 0 0
3 9 271 108 230 50 1 384F 0
3 1 303 108 230 50 0 0 0
3 14 303 108 230 50 1 384F 0
4 2 47 450 0 0 1 384F 0
4 1 47 418 0 0 0 0 0
4 17 47 418 100 350 1 384F 0
4 1 47 450 100 350 0 0 0
4 1 175 418 100 350 1 384F 0
4 1 0 0 100 390 0 0 1
5 21 335 418 0 0 1 384F 0
5 32 367 418 0 0 1 384F 0
5 16 271 418 350 350 1 384F 0
5 8 335 418 350 350 1 384F 0
5 1 375 418 350 350 1 384F 0
5 7 271 418 0 0 1 384F 0
5 8 335 418 0 0 1 384F 0

/* filelist.f */
source/spikePkg.sv
source/spikeSprite.sv
source/slideTrap.sv
source/riseTrap.sv
source/sweepTrap.sv
source/spikeField.sv
verif/spikeFieldTb.sv

/* Bender.yml */
package:
  name: spikefield

sources:
  - files:
      - source/spikePkg.sv
      - source/spikeSprite.sv
      - source/slideTrap.sv
      - source/riseTrap.sv
      - source/sweepTrap.sv
      - source/spikeField.sv
  - target: test
    files:
      - verif/spikeFieldTb.sv

/* verif/spikeFieldTb.sv */
`timescale 1ns/10ps

module spikeFieldTb;

	localparam int clkHalf = 4; // 8 ns period
	localparam int resetCycles = 3;
	localparam int marginCycles = 100;

	logic frame_clk;
	logic arstN;
	spikePkg::coordT drawX, drawY, kidX, kidY;
	logic isSpike;
	spikePkg::spriteAddrT spikeAddr;
	logic hitSpike;

	int caseId [$];
	int caseWait [$];
	spikePkg::coordT caseDrawX [$], caseDrawY [$], caseKidX [$], caseKidY [$];
	logic expSpike [$];
	spikePkg::spriteAddrT expAddr [$];
	logic expHit [$];

	logic casesLoaded = 1'b0;
	int limitCycles;
	int testCount, checkCount, errorCount;
	int testChecks, testErrors;

	spikeField u_dut (
		.frame_clk(frame_clk), .arstN(arstN), .drawX(drawX), .drawY(drawY),
		.kidX(kidX), .kidY(kidY),
		.isSpike(isSpike), .spikeAddr(spikeAddr), .hitSpike(hitSpike));

	initial
	begin
		frame_clk = 1'b0;
		forever #clkHalf frame_clk = ~frame_clk;
	end

	task automatic loadCases(output bit ok);
		int fd;
		int n;
		int id, waitCycles, dx, dy, kx, ky, es, ea, eh;
		string line;
		ok = 1'b0;
		fd = $fopen("verif/spikeCases.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the case file verif/spikeCases.txt");
			return;
		end
		while (!$feof(fd))
		begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() == 0 || line[0] == "#")
				continue; // column legend
			n = $sscanf(line, "%d %d %d %d %d %d %d %h %d", id, waitCycles, dx, dy, kx, ky,
				es, ea, eh);
			if (n == 9)
			begin
				caseId.push_back(id);
				caseWait.push_back(waitCycles);
				caseDrawX.push_back(spikePkg::coordT'(dx));
				caseDrawY.push_back(spikePkg::coordT'(dy));
				caseKidX.push_back(spikePkg::coordT'(kx));
				caseKidY.push_back(spikePkg::coordT'(ky));
				expSpike.push_back(es[0]);
				expAddr.push_back(spikePkg::spriteAddrT'(ea));
				expHit.push_back(eh[0]);
			end
		end
		$fclose(fd);
		ok = (caseId.size() > 0);
	endtask

	task automatic driveCase(input int i);
		drawX = caseDrawX[i];
		drawY = caseDrawY[i];
		kidX = caseKidX[i];
		kidY = caseKidY[i];
	endtask

	task automatic checkCase(input int i);
		if (isSpike !== expSpike[i])
		begin
			$display("ERROR case %0d: isSpike got %h expected %h", i + 1, isSpike, expSpike[i]);
			testErrors++;
		end
		if (spikeAddr !== expAddr[i])
		begin
			$display("ERROR case %0d: spikeAddr got %h expected %h", i + 1, spikeAddr,
				expAddr[i]);
			testErrors++;
		end
		if (hitSpike !== expHit[i])
		begin
			$display("ERROR case %0d: hitSpike got %h expected %h", i + 1, hitSpike, expHit[i]);
			testErrors++;
		end
		testChecks += 3;
	endtask

	task automatic reportTest(input int id);
		$display("test %0d finished: %0d checks, %0d errors", id, testChecks, testErrors);
		testCount++;
		checkCount += testChecks;
		errorCount += testErrors;
		testChecks = 0;
		testErrors = 0;
	endtask

	initial
	begin
		bit loaded;
		int curTest;
		int totalWait;
		arstN = 1'b0;
		drawX = '0;
		drawY = '0;
		kidX = '0;
		kidY = '0;
		testCount = 0;
		checkCount = 0;
		errorCount = 0;
		testChecks = 0;
		testErrors = 0;
		void'($urandom(91249));
		loadCases(loaded);
		if (!loaded)
		begin
			$display("no usable cases were found in the case file");
			$display("TEST FAILED");
			$finish;
		end
		else
		begin
			totalWait = 0;
			foreach (caseWait[i])
				totalWait += caseWait[i];
			limitCycles = totalWait + marginCycles + resetCycles;
			casesLoaded = 1'b1;
			repeat (resetCycles)
			begin
				@(posedge frame_clk);
				#1;
				drawX = spikePkg::coordT'($urandom % 640); // idle pixel, not checked
				drawY = spikePkg::coordT'($urandom % 480);
			end
			arstN = 1'b1;
			curTest = caseId[0];
			for (int i = 0; i < caseId.size(); i++)
			begin
				if (caseId[i] != curTest)
				begin
					reportTest(curTest);
					curTest = caseId[i];
				end
				driveCase(i);
				repeat ((caseWait[i] < 1) ? 1 : caseWait[i])
				begin
					@(posedge frame_clk);
					#1;
				end
				checkCase(i); // positions settled since the edge
			end
			reportTest(curTest);
			$display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
			if (errorCount == 0)
				$display("TEST OK");
			else
				$display("TEST FAILED");
			$finish;
		end
	end

	initial
	begin
		wait (casesLoaded === 1'b1);
		repeat (limitCycles) @(posedge frame_clk);
		$display("timeout: the cases did not finish within %0d clock cycles", limitCycles);
		$display("TEST FAILED");
		$finish;
	end

endmodule

/* source/spikeField.sv */
`timescale 1ns/10ps

module spikeField #(
	parameter spikePkg::spriteAddrT spriteBase = spikePkg::spikeBase,
	parameter spikePkg::coordT slideStep = 10'd4,
	parameter spikePkg::coordT riseStep = 10'd2,
	parameter spikePkg::coordT sweepStep = 10'd6,
	parameter spikePkg::coordT slowStep = 10'd4,
	parameter spikePkg::coordT fastStep = 10'd8
) (
	input logic frame_clk,
	input logic arstN,
	input spikePkg::coordT drawX,
	input spikePkg::coordT drawY,
	input spikePkg::coordT kidX,
	input spikePkg::coordT kidY,
	output logic isSpike,
	output spikePkg::spriteAddrT spikeAddr,
	output logic hitSpike
);

	localparam int slideIdx = spikePkg::numStatic;
	localparam int rowIdx = slideIdx + 1;
	localparam int rowLen = 5;
	localparam int sweepIdx = rowIdx + rowLen;
	localparam int numSpikes = sweepIdx + 2; // 13 sprites

	spikePkg::coordT posX [numSpikes];
	spikePkg::coordT posY [numSpikes];
	spikePkg::spriteAddrT texelAddr [numSpikes];
	logic [numSpikes-1:0] covered, hit;
	spikePkg::coordT slideX, rowX, rowY, leftX, rightX;

	slideTrap #(.slideStep(slideStep)) uSlide (
		.frame_clk(frame_clk), .arstN(arstN), .kidX(kidX), .kidY(kidY), .spikeX(slideX));

	riseTrap #(.riseStep(riseStep), .sweepStep(sweepStep)) uRise (
		.frame_clk(frame_clk), .arstN(arstN), .kidX(kidX), .kidY(kidY),
		.rowX(rowX), .rowY(rowY));

	sweepTrap #(.slowStep(slowStep), .fastStep(fastStep)) uSweep (
		.frame_clk(frame_clk), .arstN(arstN), .kidX(kidX), .kidY(kidY),
		.leftX(leftX), .rightX(rightX));

	for (genvar k = 0; k < spikePkg::numStatic; k++)
	begin : gStatic
		assign posX[k] = spikePkg::staticX[k];
		assign posY[k] = spikePkg::staticY[k];
	end

	assign posX[slideIdx] = slideX;
	assign posY[slideIdx] = spikePkg::slideY;

	for (genvar k = 0; k < rowLen; k++)
	begin : gRow
		assign posX[rowIdx+k] = rowX + spikePkg::rowPitch * spikePkg::coordT'(k);
		assign posY[rowIdx+k] = rowY;
	end

	assign posX[sweepIdx] = leftX;
	assign posY[sweepIdx] = spikePkg::floorY;
	assign posX[sweepIdx+1] = rightX;
	assign posY[sweepIdx+1] = spikePkg::floorY;

	for (genvar k = 0; k < numSpikes; k++)
	begin : gSprite
		spikeSprite #(.spriteBase(spriteBase)) uSprite (
			.posX(posX[k]), .posY(posY[k]), .drawX(drawX), .drawY(drawY),
			.kidX(kidX), .kidY(kidY),
			.covered(covered[k]), .texelAddr(texelAddr[k]), .hit(hit[k]));
	end

	// spikes never overlap, so at most one address is nonzero
	always_comb
	begin
		spikeAddr = '0;
		for (int i = 0; i < numSpikes; i++)
			spikeAddr = spikeAddr | texelAddr[i];
	end

	assign isSpike = |covered;
	assign hitSpike = |hit;

endmodule

/* source/sweepTrap.sv */
`timescale 1ns/10ps

module sweepTrap #(
	parameter spikePkg::coordT slowStep = 10'd4,
	parameter spikePkg::coordT fastStep = 10'd8
) (
	input logic frame_clk,
	input logic arstN,
	input spikePkg::coordT kidX,
	input spikePkg::coordT kidY,
	output spikePkg::coordT leftX,
	output spikePkg::coordT rightX
);

	typedef enum logic [2:0] {start, forward, back, forwardFast, backFast} stateT;

	stateT state, stateNext;
	spikePkg::coordT leftXNext, rightXNext;
	logic [3:0] slowCnt, slowCntNext;
	logic [2:0] fastCnt, fastCntNext;
	logic inZone;

	// player standing between the two spikes
	assign inZone = (kidX >= spikePkg::sweepZoneLeft) && (kidX <= spikePkg::sweepZoneRight)
		&& (kidY > spikePkg::zoneMinY);

	always_ff @(posedge frame_clk or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= start;
			leftX <= spikePkg::sweepLeftHome;
			rightX <= spikePkg::sweepRightHome;
			slowCnt <= '0;
			fastCnt <= '0;
		end
		else
		begin
			state <= stateNext;
			leftX <= leftXNext;
			rightX <= rightXNext;
			slowCnt <= slowCntNext;
			fastCnt <= fastCntNext;
		end
	end

	always_comb
	begin
		stateNext = state;
		leftXNext = leftX;
		rightXNext = rightX;
		slowCntNext = slowCnt;
		fastCntNext = fastCnt;
		case (state)
			start:
				stateNext = forward;
			forward:
			begin
				leftXNext = leftX + slowStep;
				rightXNext = rightX - slowStep;
				slowCntNext = slowCnt + 4'd1;
				if (slowCnt == 4'd15)
					stateNext = inZone ? backFast : back;
			end
			back:
			begin
				leftXNext = leftX - slowStep;
				rightXNext = rightX + slowStep;
				slowCntNext = slowCnt + 4'd1;
				if (slowCnt == 4'd15)
					stateNext = inZone ? forwardFast : forward;
			end
			forwardFast:
			begin
				leftXNext = leftX + fastStep;
				rightXNext = rightX - fastStep;
				fastCntNext = fastCnt + 3'd1;
				if (fastCnt == 3'd7)
					stateNext = backFast;
			end
			default:
			begin
				leftXNext = leftX - fastStep; // backFast
				rightXNext = rightX + fastStep;
				fastCntNext = fastCnt + 3'd1;
				if (fastCnt == 3'd7)
					stateNext = forwardFast;
			end
		endcase
	end

	// pair stays mirrored about the zone centre
	assert property (@(posedge frame_clk) disable iff (!arstN)
		11'(leftX) + 11'(rightX)
		== 11'(spikePkg::sweepLeftHome) + 11'(spikePkg::sweepRightHome));

endmodule

/* source/riseTrap.sv */
`timescale 1ns/10ps

module riseTrap #(
	parameter spikePkg::coordT riseStep = 10'd2,
	parameter spikePkg::coordT sweepStep = 10'd6
) (
	input logic frame_clk,
	input logic arstN,
	input spikePkg::coordT kidX,
	input spikePkg::coordT kidY,
	output spikePkg::coordT rowX,
	output spikePkg::coordT rowY
);

	// finished is the resting state once the sweep is over
	typedef enum logic [2:0] {ready, up, upWait, forward, back, finished} stateT;

	stateT state, stateNext;
	spikePkg::coordT rowXNext, rowYNext;
	logic [3:0] passCnt, passCntNext;
	logic inZone;

	assign inZone = (kidX >= spikePkg::riseZoneLeft) && (kidX <= spikePkg::riseZoneRight)
		&& (kidY > spikePkg::zoneMinY);

	always_ff @(posedge frame_clk or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= ready;
			rowX <= spikePkg::riseHomeX;
			rowY <= spikePkg::riseHomeY;
			passCnt <= '0;
		end
		else
		begin
			state <= stateNext;
			rowX <= rowXNext;
			rowY <= rowYNext;
			passCnt <= passCntNext;
		end
	end

	always_comb
	begin
		stateNext = state;
		rowXNext = rowX;
		rowYNext = rowY;
		passCntNext = passCnt;
		case (state)
			ready:
			begin
				passCntNext = '0;
				if (inZone)
					stateNext = up;
			end
			up:
			begin
				rowYNext = rowY - riseStep;
				passCntNext = passCnt + 4'd1; // 16 steps, wraps back to 0
				if (passCnt == 4'd15)
					stateNext = upWait;
			end
			upWait:
				if ((kidX >= spikePkg::riseZoneRight) && (kidY == spikePkg::floorY))
					stateNext = forward;
			forward:
			begin
				rowXNext = rowX + sweepStep;
				passCntNext = passCnt + 4'd1;
				if (passCnt == 4'd15)
					stateNext = back;
			end
			back:
			begin
				rowXNext = rowX - sweepStep;
				passCntNext = passCnt + 4'd1;
				if (passCnt == 4'd15)
					stateNext = finished;
			end
			default: ;
		endcase
	end

	// row pokes up to the floor line and no further
	assert property (@(posedge frame_clk) disable iff (!arstN)
		(state != ready) |-> (rowY >= spikePkg::floorY));

endmodule

/* source/slideTrap.sv */
`timescale 1ns/10ps

module slideTrap #(
	parameter spikePkg::coordT slideStep = 10'd4
) (
	input logic frame_clk,
	input logic arstN,
	input spikePkg::coordT kidX,
	input spikePkg::coordT kidY,
	output spikePkg::coordT spikeX
);

	typedef enum logic [2:0] {ready, forward, wait1, wait2, wait3, back, finish} stateT;

	stateT state, stateNext;
	spikePkg::coordT spikeXNext;
	logic [2:0] stepCnt, stepCntNext;
	logic [2:0] dwellCnt, dwellCntNext;
	logic armed, armedNext;
	logic [1:0] trigCnt, trigCntNext;
	logic trigger;

	// player passed the spike while up on the ledge
	assign trigger = armed && (kidX > spikePkg::slideTriggerX) && (kidY < spikePkg::slideY);

	always_ff @(posedge frame_clk or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= ready;
			spikeX <= spikePkg::slideHomeX;
			stepCnt <= '0;
			dwellCnt <= '0;
			armed <= 1'b1;
			trigCnt <= '0;
		end
		else
		begin
			state <= stateNext;
			spikeX <= spikeXNext;
			stepCnt <= stepCntNext;
			dwellCnt <= dwellCntNext;
			armed <= armedNext;
			trigCnt <= trigCntNext;
		end
	end

	always_comb
	begin
		stateNext = state;
		spikeXNext = spikeX;
		stepCntNext = stepCnt;
		dwellCntNext = dwellCnt;
		armedNext = armed;
		trigCntNext = trigCnt;
		case (state)
			ready:
			begin
				spikeXNext = spikePkg::slideHomeX;
				stepCntNext = '0;
				if (kidX < spikePkg::slideTriggerX)
					armedNext = 1'b1;
				if (trigger)
				begin
					stateNext = forward;
					armedNext = 1'b0;
					trigCntNext = trigCnt + 2'd1; // once per trigger
				end
			end
			forward:
			begin
				spikeXNext = spikeX - slideStep;
				stepCntNext = stepCnt + 3'd1; // wraps to 0 for back
				if (stepCnt == 3'd7)
					stateNext = wait1;
			end
			wait1:
			begin
				dwellCntNext = dwellCnt + 3'd1;
				if (dwellCnt == 3'd4)
					stateNext = wait2;
			end
			wait2:
			begin
				dwellCntNext = '0;
				stateNext = wait3;
			end
			wait3:
				stateNext = back;
			back:
			begin
				spikeXNext = spikeX + slideStep;
				stepCntNext = stepCnt + 3'd1;
				if (stepCnt == 3'd7)
					stateNext = (trigCnt == 2'd3) ? finish : ready;
			end
			default:
				spikeXNext = spikePkg::slideHomeX; // finish, parked for good
		endcase
	end

	// lunge never leaves the eight-step span left of home
	assert property (@(posedge frame_clk) disable iff (!arstN)
		(spikeX <= spikePkg::slideHomeX)
		&& (spikeX >= spikePkg::slideHomeX - spikePkg::coordT'(8) * slideStep));

endmodule

/* source/spikeSprite.sv */
`timescale 1ns/10ps

module spikeSprite #(
	parameter spikePkg::spriteAddrT spriteBase = spikePkg::spikeBase
) (
	input spikePkg::coordT posX,
	input spikePkg::coordT posY,
	input spikePkg::coordT drawX,
	input spikePkg::coordT drawY,
	input spikePkg::coordT kidX,
	input spikePkg::coordT kidY,
	output logic covered,
	output spikePkg::spriteAddrT texelAddr,
	output logic hit
);

	spikePkg::coordT dx, dy;
	spikePkg::coordT depth, mirror;
	spikePkg::coordT leftEdge, rightEdge;
	logic inBox;
	spikePkg::coordT boxLeft, boxRight, boxTop, boxBottom;
	spikePkg::coordT ptX [6];
	spikePkg::coordT ptY [6];
	logic [5:0] ptHit;

	assign dx = drawX - posX; // wraps high when left of the box
	assign dy = drawY - posY;
	assign inBox = (dx < spikePkg::spikeSize) && (dy < spikePkg::spikeSize);

	assign depth = spikePkg::spikeSize - dy;         // 1 on the base row
	assign mirror = (spikePkg::spikeSize - 10'd1) - dx;
	assign leftEdge = dx + dx;
	assign rightEdge = mirror + mirror;

	always_comb
	begin
		covered = 1'b0;
		if (inBox)
		begin
			if (dx < (spikePkg::spikeSize >> 1))
				covered = (depth <= leftEdge);
			else
				covered = (depth <= rightEdge);
		end
	end

	// row-major texture
	assign texelAddr = covered ? spriteBase + spikePkg::spriteAddrT'(dx)
		+ spikePkg::spriteAddrT'(dy) * spikePkg::spriteAddrT'(spikePkg::spikeSize) : '0;

	assign boxLeft = kidX + spikePkg::hitLeft;
	assign boxRight = kidX + spikePkg::hitRight;
	assign boxTop = kidY + spikePkg::hitTop;
	assign boxBottom = kidY + spikePkg::hitBottom;

	// apex, two midsides, three base points
	assign ptX = '{posX + 10'd15, posX + 10'd8, posX + 10'd24,
		posX, posX + 10'd15, posX + 10'd31};
	assign ptY = '{posY, posY + 10'd15, posY + 10'd15,
		posY + 10'd31, posY + 10'd31, posY + 10'd31};

	for (genvar k = 0; k < 6; k++)
	begin : gPoint
		assign ptHit[k] = (ptX[k] >= boxLeft) && (ptX[k] <= boxRight)
			&& (ptY[k] >= boxTop) && (ptY[k] <= boxBottom);
	end

	assign hit = |ptHit;

endmodule

/* source/spikePkg.sv */
package spikePkg;

	typedef logic [9:0] coordT;       // screen coordinate
	typedef logic [24:0] spriteAddrT; // sprite memory word address

	// spike sprite geometry
	localparam coordT spikeSize = 10'd32;
	localparam spriteAddrT spikeBase = 25'd14336; // right after the player frames

	// player hitbox offsets from kidX and kidY
	localparam coordT hitLeft = 10'd8;
	localparam coordT hitRight = 10'd22;
	localparam coordT hitTop = 10'd10;
	localparam coordT hitBottom = 10'd31;

	localparam int numStatic = 5;
	localparam coordT staticX [numStatic] = '{10'd96, 10'd160, 10'd224, 10'd320, 10'd450};
	localparam coordT staticY [numStatic] = '{10'd106, 10'd106, 10'd106, 10'd135, 10'd244};

	// slide trap on the upper ledge
	localparam coordT slideHomeX = 10'd288;
	localparam coordT slideY = 10'd106;
	localparam coordT slideTriggerX = 10'd222;

	// rise trap, row starts hidden under the floor
	localparam coordT riseHomeX = 10'd32;
	localparam coordT riseHomeY = 10'd448;
	localparam coordT riseZoneLeft = 10'd32;
	localparam coordT riseZoneRight = 10'd192;
	localparam coordT zoneMinY = 10'd300; // player counts as on the lower floor below this
	localparam coordT floorY = 10'd416;

	// sweep trap pair
	localparam coordT sweepLeftHome = 10'd256;
	localparam coordT sweepRightHome = 10'd416;
	localparam coordT sweepZoneLeft = 10'd288;
	localparam coordT sweepZoneRight = 10'd416;

	localparam coordT rowPitch = 10'd32; // spacing in the rise row

endpackage
